/* build.f */
+incdir+design
design/fetch_types_pkg.sv
design/wb_bus_pkg.sv
design/prefetch_fifo.sv
design/fetch_ctrl.sv
design/prefetch_buffer.sv
tests/prefetch_checker.sv
tests/prefetch_tb.sv

/* run.sh */
#!/bin/sh
# build the prefetch buffer testbench with Verilator and run it
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f build.f --top-module prefetch_tb \
    -o prefetch_sim > build.log 2>&1 \
    && ./obj_dir/prefetch_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error, see build.log and sim.log"

grep -q "^Simulation PASSED$" sim.log && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }

/* tests/prefetch_stim.txt */
# prefetch buffer tests, one per line, all fields hex
# phase target1 target2 max_wait ready_mode gap_or_hold words
# phase 0 = keep the current stream, 1 = branch with fetch idle
# phase 2 = branch during a read, 3 = two branches back to back
# ready_mode 0 = always ready, 1 = random gaps up to gap, 2 = hold until full
0 00000000 00000000 0 0 0 a
0 00000000 00000000 5 0 0 c
0 00000000 00000000 2 1 3 10
0 00000000 00000000 1 2 8 a
1 00002000 00000000 2 0 0 8
2 00003000 00000000 4 0 0 8
2 00003400 00000000 5 1 2 a
3 00004000 00005000 3 0 0 8
1 00006000 00000000 0 1 1 8
3 00007000 00007800 1 1 2 8
2 00008000 00000000 3 2 6 a
0 00000000 00000000 5 1 5 c
1 0000a000 00000000 4 0 6 6
3 0000b000 0000c000 5 1 3 9
0 00000000 00000000 0 0 0 14

/* tests/prefetch_tb.sv */
//////////////////////////////////////////////////////////////////////
// prefetch buffer testbench
// Wishbone memory model, file driven tests, core side scoreboard
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "prefetch_settings.svh"

module prefetch_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          MAX_TESTS = 32;
    localparam logic [31:0] DATA_KEY  = 32'hC0DE_0000;

    logic        clk_i;
    logic        rst_ni;
    logic        branch_i;
    logic [31:0] branch_addr_i;
    logic        instr_ready_i;
    logic        instr_valid_o;
    logic [31:0] instr_rdata_o;
    logic [31:0] instr_addr_o;
    logic [31:0] wb_dat_i;
    logic        wb_ack_i;
    logic        wb_cyc_o;
    logic        wb_stb_o;
    logic [31:0] wb_adr_o;
    logic [3:0]  wb_sel_o;
    logic        wb_we_o;

    // test table from the stimulus file
    int          num_tests;
    int          t_phase [MAX_TESTS];
    logic [31:0] t_tgt1 [MAX_TESTS];
    logic [31:0] t_tgt2 [MAX_TESTS];
    int          t_wait [MAX_TESTS];
    int          t_mode [MAX_TESTS];
    int          t_gap [MAX_TESTS];
    int          t_words [MAX_TESTS];

    int          wait_seed;
    int          ready_seed;
    int          wait_max;
    int          wait_min;
    int          wait_left;
    logic        mem_busy;

    // scoreboard state
    logic [31:0] exp_addr;
    int          test_acc;
    int          check_cnt;
    int          err_cnt;
    int          cycle_cnt;
    int          cycle_limit;
    logic        limit_ready;

    prefetch_buffer DUT (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .branch_i      (branch_i),
        .branch_addr_i (branch_addr_i),
        .instr_ready_i (instr_ready_i),
        .instr_valid_o (instr_valid_o),
        .instr_rdata_o (instr_rdata_o),
        .instr_addr_o  (instr_addr_o),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_adr_o      (wb_adr_o),
        .wb_sel_o      (wb_sel_o),
        .wb_we_o       (wb_we_o)
    );

    always #2 clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // Wishbone slave, data is the address XOR a fixed key
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin
        if (!rst_ni) begin
            wb_ack_i = 1'b0;
            mem_busy = 1'b0;
        end else if (wb_ack_i) begin
            // ack lasts a single cycle
            wb_ack_i = 1'b0;
            wb_dat_i = 32'h0;
            mem_busy = 1'b0;
        end else if (wb_cyc_o && wb_stb_o) begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                wait_left = wait_min + int'($unsigned($random(wait_seed))
                            % (wait_max - wait_min + 1));
                // plain word reads only
                assert (wb_sel_o == 4'hf) else begin
                    $display("Mismatch at %0t: wb_sel_o expected f got %h",
                             $time, wb_sel_o);
                    err_cnt = err_cnt + 1;
                end
                assert (wb_we_o == 1'b0) else begin
                    $display("Mismatch at %0t: wb_we_o expected 0 got %b",
                             $time, wb_we_o);
                    err_cnt = err_cnt + 1;
                end
            end
            if (wait_left == 0) begin
                wb_ack_i = 1'b1;
                wb_dat_i = wb_adr_o ^ DATA_KEY;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // scoreboard and timeout
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (rst_ni && instr_valid_o && instr_ready_i) begin
            check_cnt = check_cnt + 1;
            assert (instr_addr_o == exp_addr) else begin
                $display("Mismatch at %0t: instr_addr_o expected %h got %h",
                         $time, exp_addr, instr_addr_o);
                err_cnt = err_cnt + 1;
            end
            assert (instr_rdata_o == (exp_addr ^ DATA_KEY)) else begin
                $display("Mismatch at %0t: instr_rdata_o expected %h got %h",
                         $time, exp_addr ^ DATA_KEY, instr_rdata_o);
                err_cnt = err_cnt + 1;
            end
            exp_addr = exp_addr + 32'd4;
            test_acc = test_acc + 1;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (limit_ready && cycle_cnt > cycle_limit) begin
            $display("Timeout: run still busy after %0d cycles", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    task automatic read_stimulus();
        int    fd;
        int    n;
        string line;
        int    ph;
        int    wt;
        int    md;
        int    gp;
        int    wd;
        logic [31:0] a1;
        logic [31:0] a2;
        fd = $fopen("tests/prefetch_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file tests/prefetch_stim.txt");
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h", ph, a1, a2, wt, md, gp, wd);
                    if (n == 7) begin
                        t_phase[num_tests] = ph;
                        t_tgt1[num_tests]  = a1;
                        t_tgt2[num_tests]  = a2;
                        t_wait[num_tests]  = wt;
                        t_mode[num_tests]  = md;
                        t_gap[num_tests]   = gp;
                        t_words[num_tests] = wd;
                        num_tests = num_tests + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // every test may take words * (waits + gaps + 3) cycles, holds on top
    task automatic set_cycle_limit();
        int sum;
        sum = 200;
        for (int i = 0; i < num_tests; i++) begin
            sum = sum + t_words[i] * (t_wait[i] + t_gap[i] + 3) + t_gap[i] + 60;
        end
        cycle_limit = sum;
        limit_ready = 1'b1;
    endtask

    // stall the core until the FIFO is full, then make sure fetch stays idle
    task automatic fill_and_hold(input int hold);
        instr_ready_i = 1'b0;
        @(negedge clk_i);
        while (wb_cyc_o || !instr_valid_o) begin
            @(negedge clk_i);
        end
        repeat (hold) begin
            assert (!wb_cyc_o) else begin
                $display("Fetch restarted at %0t while the FIFO was full", $time);
                err_cnt = err_cnt + 1;
            end
            @(negedge clk_i);
        end
    endtask

    // returns at the negedge where a fresh read has just been issued
    task automatic wait_new_read();
        logic        prev_cyc;
        logic [31:0] prev_adr;
        instr_ready_i = 1'b1;
        prev_cyc = wb_cyc_o;
        prev_adr = wb_adr_o;
        @(negedge clk_i);
        while (!(wb_cyc_o && (!prev_cyc || wb_adr_o != prev_adr))) begin
            prev_cyc = wb_cyc_o;
            prev_adr = wb_adr_o;
            @(negedge clk_i);
        end
    endtask

    // one branch cycle, core stalled so no old word is taken at that edge
    task automatic pulse_branch(input logic [31:0] tgt);
        instr_ready_i = 1'b0;
        branch_i      = 1'b1;
        branch_addr_i = tgt;
        exp_addr      = tgt;
        test_acc      = 0;
        @(negedge clk_i);
        branch_i      = 1'b0;
    endtask

    // in random mode ready drops for up to gap cycles before each word
    task automatic collect_words(input int n, input int mode, input int gap);
        int stall;
        int taken;
        while (test_acc < n) begin
            if (mode == 1) begin
                stall = int'($unsigned($random(ready_seed)) % (gap + 1));
                instr_ready_i = 1'b0;
                repeat (stall) begin
                    @(negedge clk_i);
                end
            end
            instr_ready_i = 1'b1;
            taken = test_acc;
            while (test_acc == taken) begin
                @(negedge clk_i);
            end
        end
        instr_ready_i = 1'b0;
    endtask

    task automatic run_test(input int idx);
        int errs_before;
        errs_before = err_cnt;
        wait_max    = t_wait[idx];
        wait_min    = (t_phase[idx] >= 2 && t_wait[idx] > 0) ? 1 : 0;
        test_acc    = 0;
        case (t_phase[idx])
            1: begin
                fill_and_hold((t_gap[idx] > 2) ? t_gap[idx] : 2);
                pulse_branch(t_tgt1[idx]);
            end
            2: begin
                wait_new_read();
                pulse_branch(t_tgt1[idx]);
            end
            3: begin
                // back to back redirects, the second one wins
                wait_new_read();
                pulse_branch(t_tgt1[idx]);
                pulse_branch(t_tgt2[idx]);
            end
            default: begin
                if (t_mode[idx] == 2) begin
                    fill_and_hold(t_gap[idx]);
                end
            end
        endcase
        collect_words(t_words[idx], t_mode[idx], t_gap[idx]);
        $display("test %0d phase %0d: %0d words, %0d errors",
                 idx, t_phase[idx], t_words[idx], err_cnt - errs_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        branch_i      = 1'b0;
        branch_addr_i = 32'h0;
        instr_ready_i = 1'b0;
        wb_dat_i      = 32'h0;
        wb_ack_i      = 1'b0;
        wait_seed     = 32'h334e;
        ready_seed    = 32'h334e;
        wait_max      = 0;
        wait_min      = 0;
        wait_left     = 0;
        mem_busy      = 1'b0;
        exp_addr      = `PF_BOOT_ADDR;
        test_acc      = 0;
        check_cnt     = 0;
        err_cnt       = 0;
        cycle_cnt     = 0;
        cycle_limit   = 0;
        limit_ready   = 1'b0;
        num_tests     = 0;

        read_stimulus();
        if (num_tests == 0) begin
            $display("No test lines found in the stimulus file");
            err_cnt = err_cnt + 1;
        end
        set_cycle_limit();

        repeat (4) @(negedge clk_i);
        // bus request and core port stay quiet in reset
        assert (!wb_cyc_o && !wb_stb_o && !instr_valid_o) else begin
            $display("Bus request or valid active during reset at %0t", $time);
            err_cnt = err_cnt + 1;
        end
        rst_ni = 1'b1;

        for (int i = 0; i < num_tests; i++) begin
            run_test(i);
        end

        $display("tests %0d, words checked %0d, errors %0d", num_tests, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/prefetch_checker.sv */
//////////////////////////////////////////////////////////////////////
// prefetch buffer protocol checker
// Wishbone request stability, FIFO overflow and core port hold rules
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "prefetch_settings.svh"

module prefetch_checker (
    input wire logic                  clk_i,
    input wire logic                  rst_ni,
    input wire logic                  branch_i,
    input wire logic                  wb_stb_i,
    input wire logic [`PF_ADDR_W-1:0] wb_adr_i,
    input wire logic                  wb_ack_i,
    input wire logic                  push_i,
    input wire logic                  full_i,
    input wire logic                  valid_i,
    input wire logic                  ready_i,
    input wire logic [`PF_DATA_W-1:0] rdata_i,
    input wire logic [`PF_ADDR_W-1:0] addr_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // classic read holds stb and address until the slave acks
    stb_held_until_ack: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (wb_stb_i && !wb_ack_i) |=> (wb_stb_i && $stable(wb_adr_i))
    ) else $error("wishbone request changed before ack");

    // one read in flight, so a push never meets a full FIFO
    no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(push_i && full_i)
    ) else $error("FIFO push while full");

    // stalled word stays put, a branch flush is the only way out
    valid_held_while_stalled: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (valid_i && !ready_i && !branch_i)
            |=> (valid_i && $stable(rdata_i) && $stable(addr_i))
    ) else $error("core port word dropped or changed while stalled");

endmodule

bind prefetch_buffer prefetch_checker u_prefetch_checker (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .branch_i (branch_i),
    .wb_stb_i (wb_stb_o),
    .wb_adr_i (wb_adr_o),
    .wb_ack_i (wb_ack_i),
    .push_i   (fifo_push),
    .full_i   (fifo_full),
    .valid_i  (instr_valid_o),
    .ready_i  (instr_ready_i),
    .rdata_i  (instr_rdata_o),
    .addr_i   (instr_addr_o)
);

`default_nettype wire

/* design/prefetch_buffer.sv */
//////////////////////////////////////////////////////////////////////
// instruction prefetch buffer
// fetch controller on Wishbone plus a FIFO of tagged words
// words leave toward the core through a valid/ready port
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "prefetch_settings.svh"

module prefetch_buffer
    import fetch_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_ni,
    // redirect
    input  wire logic         branch_i,
    input  wire fetch_addr_t  branch_addr_i,
    // core port
    input  wire logic         instr_ready_i,
    output logic              instr_valid_o,
    output instr_t            instr_rdata_o,
    output fetch_addr_t       instr_addr_o,
    // Wishbone master
    input  wire wb_data_t     wb_dat_i,
    input  wire logic         wb_ack_i,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output wb_addr_t          wb_adr_o,
    output wb_sel_t           wb_sel_o,
    output logic              wb_we_o
);

    logic                            fifo_push;
    logic                            fifo_flush;
    logic                            fifo_pop;
    logic                            fifo_full;
    logic                            fifo_empty;
    fifo_cnt_t                       fifo_cnt;
    logic [`PF_ADDR_W+`PF_DATA_W-1:0] fifo_wdata;
    logic [`PF_ADDR_W+`PF_DATA_W-1:0] fifo_rdata;

    fetch_ctrl u_fetch_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .branch_i      (branch_i),
        .branch_addr_i (branch_addr_i),
        .fifo_full_i   (fifo_full),
        .fifo_cnt_i    (fifo_cnt),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_adr_o      (wb_adr_o),
        .fifo_push_o   (fifo_push),
        .fifo_flush_o  (fifo_flush),
        .fifo_data_o   (fifo_wdata)
    );

    // registered output, one cycle from ack to valid
    prefetch_fifo #(
        .FALL_THROUGH (1'b0),
        .DEPTH        (`PF_FIFO_DEPTH),
        .dtype        (logic [`PF_ADDR_W+`PF_DATA_W-1:0])
    ) u_prefetch_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (fifo_flush),
        .push_i  (fifo_push),
        .data_i  (fifo_wdata),
        .pop_i   (fifo_pop),
        .full_o  (fifo_full),
        .empty_o (fifo_empty),
        .cnt_o   (fifo_cnt),
        .data_o  (fifo_rdata)
    );

    // core handshake
    assign instr_valid_o = !fifo_empty;
    assign fifo_pop      = instr_valid_o && instr_ready_i;
    assign {instr_addr_o, instr_rdata_o} = fifo_rdata;

    // read-only master, full word lanes
    assign wb_sel_o = '1;
    assign wb_we_o  = 1'b0;

endmodule

`default_nettype wire

/* design/fetch_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// fetch controller
// Wishbone classic read master feeding the prefetch FIFO
// walks sequential word addresses while the FIFO has room
// a branch flushes the FIFO and redirects, dropping a read in flight
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "prefetch_settings.svh"

module fetch_ctrl
    import fetch_types_pkg::*;
    import wb_bus_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_ni,
    // redirect from the core
    input  wire logic         branch_i,
    input  wire fetch_addr_t  branch_addr_i,
    // FIFO status
    input  wire logic         fifo_full_i,
    input  wire fifo_cnt_t    fifo_cnt_i,
    // Wishbone slave response
    input  wire wb_data_t     wb_dat_i,
    input  wire logic         wb_ack_i,
    // Wishbone master request
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output wb_addr_t          wb_adr_o,
    // FIFO write side
    output logic              fifo_push_o,
    output logic              fifo_flush_o,
    output logic [`PF_ADDR_W+`PF_DATA_W-1:0] fifo_data_o
);

    // address step of one instruction word
    localparam fetch_addr_t WORD_STEP = fetch_addr_t'(4);
    // count below which one more push still leaves a free slot
    localparam fifo_cnt_t LAST_SLOT = fifo_cnt_t'(`PF_FIFO_DEPTH - 1);

    fetch_state_e state_q;
    fetch_state_e state_d;

    // address of the read on the bus, or the next one to issue
    fetch_addr_t addr_q;
    fetch_addr_t addr_d;

    // branch target parked while a killed read completes
    fetch_addr_t tgt_q;
    fetch_addr_t tgt_d;

    logic room_after_ack;

    // the acked word still leaves room for another one
    assign room_after_ack = (fifo_cnt_i < LAST_SLOT);

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d     = state_q;
        addr_d      = addr_q;
        tgt_d       = tgt_q;
        fifo_push_o = 1'b0;

        unique case (state_q)
            IDLE: begin
                // nothing in flight, redirect right away
                if (branch_i) begin
                    addr_d  = branch_addr_i;
                    state_d = REQ;
                end else if (!fifo_full_i) begin
                    state_d = REQ;
                end
            end

            REQ: begin
                if (wb_ack_i) begin
                    if (branch_i) begin
                        // read ends this cycle, its word is stale
                        addr_d  = branch_addr_i;
                        state_d = REQ;
                    end else begin
                        fifo_push_o = 1'b1;
                        addr_d      = addr_q + WORD_STEP;
                        state_d     = room_after_ack ? REQ : IDLE;
                    end
                end else if (branch_i) begin
                    // keep cyc/stb and address until the slave acks
                    tgt_d   = branch_addr_i;
                    state_d = DROP;
                end
            end

            DROP: begin
                // a later branch replaces the parked target
                if (branch_i) begin
                    tgt_d = branch_addr_i;
                end
                if (wb_ack_i) begin
                    addr_d  = branch_i ? branch_addr_i : tgt_q;
                    state_d = REQ;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            addr_q  <= `PF_BOOT_ADDR;
        end else begin
            state_q <= state_d;
            addr_q  <= addr_d;
        end
    end

    always_ff @(posedge clk_i) begin
        tgt_q <= tgt_d;
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    // cyc and stb move together for single classic reads
    assign wb_cyc_o = (state_q != IDLE);
    assign wb_stb_o = (state_q != IDLE);
    assign wb_adr_o = wb_addr_t'(addr_q);

    // flush in the branch cycle itself
    assign fifo_flush_o = branch_i;

    // word tagged with the address it came from
    assign fifo_data_o = {addr_q, instr_t'(wb_dat_i)};

endmodule

`default_nettype wire

/* design/prefetch_fifo.sv */
//////////////////////////////////////////////////////////////////////
// prefetch FIFO
// circular buffer with read/write pointers and an occupancy counter
// optional fall-through output for a push into an empty FIFO
// synchronous flush wins over push and pop in the same cycle
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "prefetch_settings.svh"

module prefetch_fifo
    import fetch_types_pkg::*;
#(
    parameter bit          FALL_THROUGH = 1'b0,
    parameter int unsigned DEPTH        = `PF_FIFO_DEPTH,
    parameter type         dtype        = logic [`PF_ADDR_W+`PF_DATA_W-1:0]
) (
    input  wire logic      clk_i,
    input  wire logic      rst_ni,
    input  wire logic      flush_i,
    input  wire logic      push_i,
    input  wire dtype      data_i,
    input  wire logic      pop_i,
    output logic           full_o,
    output logic           empty_o,
    output fifo_cnt_t      cnt_o,
    output dtype           data_o
);

    // pointer width, at least one bit even for a single entry
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] rd_ptr_d;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] wr_ptr_d;
    fifo_cnt_t        cnt_q;
    fifo_cnt_t        cnt_d;

    // storage, written only by an accepted push
    dtype mem_q [DEPTH];

    logic bypass;
    logic through;
    logic push_ok;
    logic pop_ok;
    logic mem_we;

    //////////////////////////////////////////////////////////////////////
    // flags and output
    //////////////////////////////////////////////////////////////////////

    // fall-through case, empty FIFO but a word arrives this cycle
    assign bypass  = FALL_THROUGH && (cnt_q == '0) && push_i;
    // word goes in and out in the same cycle
    assign through = bypass && pop_i;

    assign full_o  = (cnt_q == fifo_cnt_t'(DEPTH));
    assign empty_o = (cnt_q == '0) && !bypass;
    assign cnt_o   = cnt_q;

    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    // head of queue, or the incoming word when bypassing
    assign data_o = bypass ? data_i : mem_q[rd_ptr_q];

    //////////////////////////////////////////////////////////////////////
    // pointer and counter update
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        cnt_d    = cnt_q;

        // a word passing straight through leaves the state alone
        if (!through) begin
            if (push_ok) begin
                wr_ptr_d = (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_d = (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            // push and pop together keep the count
            unique case ({push_ok, pop_ok})
                2'b10:   cnt_d = cnt_q + 1'b1;
                2'b01:   cnt_d = cnt_q - 1'b1;
                default: cnt_d = cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            // flush drops every entry, pending push included
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            cnt_q    <= cnt_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // no write for a flushed or bypassed word
    assign mem_we = push_ok && !through && !flush_i;

    always_ff @(posedge clk_i) begin
        if (mem_we) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

/* design/wb_bus_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Wishbone bus types
// address, read data and byte select vectors of the fetch port
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "prefetch_settings.svh"

package wb_bus_pkg;

    typedef logic [`PF_ADDR_W-1:0] wb_addr_t;

    typedef logic [`PF_DATA_W-1:0] wb_data_t;

    // one select bit per byte lane
    typedef logic [`PF_DATA_W/8-1:0] wb_sel_t;

endpackage

`default_nettype wire

/* design/fetch_types_pkg.sv */
//////////////////////////////////////////////////////////////////////
// fetch side types
// instruction addresses, words, FIFO occupancy and the fetch FSM
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "prefetch_settings.svh"

package fetch_types_pkg;

    // byte address of one instruction word
    typedef logic [`PF_ADDR_W-1:0] fetch_addr_t;

    // raw instruction word as seen by the core
    typedef logic [`PF_DATA_W-1:0] instr_t;

    // occupancy, has to reach the depth value itself
    typedef logic [$clog2(`PF_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

    // fetch FSM, DROP waits out a read killed by a branch
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        DROP
    } fetch_state_e;

endpackage

`default_nettype wire

/* design/prefetch_settings.svh */
//////////////////////////////////////////////////////////////////////
// prefetch buffer build settings
// boot address, FIFO depth and bus widths shared by every block
//////////////////////////////////////////////////////////////////////

`ifndef PREFETCH_SETTINGS_SVH
`define PREFETCH_SETTINGS_SVH

// first word fetched after reset, byte address
`define PF_BOOT_ADDR 32'h0000_1000

// number of fetched words buffered ahead of the core
`define PF_FIFO_DEPTH 4

// bus address and data widths
`define PF_ADDR_W 32
`define PF_DATA_W 32

`endif
